// File: rtl/icache_pkg.sv
// fixed geometry: 24-bit byte address = 10-bit tag, 9-bit index, 3-bit word, 2-bit byte
// the address split in the cache and refill logic assumes exactly these widths
`default_nettype none

package icache_pkg;

  localparam int TAG_W          = 10;
  localparam int INDEX_W        = 9;   // 512 lines
  localparam int WORD_W         = 3;   // 8 words per line
  localparam int NUM_LINES      = 512;
  localparam int WORDS_PER_LINE = 8;

  typedef struct packed {
    logic [TAG_W-1:0]   tag;
    logic [INDEX_W-1:0] index;
    logic [WORD_W-1:0]  word;
    logic [1:0]         byte_off;  // ignored, fetches are word aligned
  } fetch_addr_t;

  typedef struct packed {
    logic [31:0] instr;
  } fetch_resp_t;

  typedef struct packed {
    logic [TAG_W+INDEX_W+WORD_W-1:0] word_addr;  // byte address bits 23:2
  } mem_req_t;

  typedef struct packed {
    logic [31:0] rdata;
  } mem_resp_t;

  typedef enum logic [1:0] {
    RF_IDLE,
    RF_WAIT_ACK,
    RF_DONE
  } refill_state_t;

endpackage

`default_nettype wire

// File: rtl/icache_refill.sv
// fetches one whole line per start, words 0..7 in order
// line_addr must stay stable from start until refill_done
`default_nettype none

module icache_refill (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    start,
  input  icache_pkg::fetch_addr_t line_addr,
  output logic                    mem_stb,
  output icache_pkg::mem_req_t    mem_req,
  input  logic                    mem_ack,
  input  icache_pkg::mem_resp_t   mem_resp,
  output logic                    fill_we,
  output logic [11:0]             fill_word_index,
  output logic [31:0]             fill_data,
  output logic                    fill_line_valid,
  output logic                    refill_done
);
  import icache_pkg::*;

  refill_state_t     state;
  logic [WORD_W-1:0] word_cnt;
  logic              last_word;

  assign last_word = (word_cnt == WORD_W'(WORDS_PER_LINE - 1));

  // strobe held with a stable address until the ack cycle
  assign mem_stb           = (state == RF_WAIT_ACK);
  assign mem_req.word_addr = {line_addr.tag, line_addr.index, word_cnt};

  assign fill_we         = mem_stb && mem_ack;  // data valid in the ack cycle
  assign fill_word_index = {line_addr.index, word_cnt};
  assign fill_data       = mem_resp.rdata;
  assign fill_line_valid = fill_we && last_word;
  assign refill_done     = (state == RF_DONE);  // one cycle after last write

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= RF_IDLE;
      word_cnt <= '0;
    end else begin
      case (state)
        RF_IDLE: begin
          if (start) begin
            state    <= RF_WAIT_ACK;
            word_cnt <= '0;
          end
        end
        RF_WAIT_ACK: begin
          if (mem_ack) begin
            word_cnt <= word_cnt + 1'b1;  // wraps to 0 after word 7
            if (last_word) begin
              state <= RF_DONE;
            end
          end
        end
        RF_DONE: begin
          state <= RF_IDLE;
        end
        default: begin
          state <= RF_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/icache.sv
// direct-mapped read-only cache; no writes, no invalidation other than reset
// valid bits sit in flops so reset clears every line in one cycle
`default_nettype none

module icache (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    valid,
  input  icache_pkg::fetch_addr_t addr,
  output logic                    ready_out,
  input  logic                    ready_in,
  output logic                    valid_out,
  output icache_pkg::fetch_resp_t data,
  output logic                    mem_stb,
  output icache_pkg::mem_req_t    mem_req,
  input  logic                    mem_ack,
  input  icache_pkg::mem_resp_t   mem_resp,
  output logic [15:0]             miss_count
);
  import icache_pkg::*;

  localparam int FILL_W = INDEX_W + WORD_W;

  logic                 valid_buf;
  fetch_addr_t          addr_buf;
  logic [NUM_LINES-1:0] line_valid;
  logic [TAG_W-1:0]     line_tag [NUM_LINES];
  logic [31:0]          line_data [NUM_LINES*WORDS_PER_LINE];  // word granular, no output mux
  logic                 rd_valid;
  logic [TAG_W-1:0]     rd_tag;
  fetch_resp_t          rd_word;
  logic                 rd_en;
  logic [INDEX_W-1:0]   rd_index;
  logic [WORD_W-1:0]    rd_offset;
  logic                 hit;
  logic                 refill_busy;
  logic                 start;
  logic                 fill_we;
  logic [FILL_W-1:0]    fill_word_index;
  logic [31:0]          fill_data;
  logic                 fill_line_valid;
  logic                 refill_done;

  assign hit       = rd_valid && (rd_tag == addr_buf.tag);
  assign ready_out = ready_in && (hit || !valid_buf);
  assign valid_out = valid_buf && hit;
  assign data      = rd_word;
  assign start     = valid_buf && !hit && !refill_busy;  // one pulse per miss

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_buf <= 1'b0;
    end else if (ready_out) begin
      valid_buf <= valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ready_out) begin
      addr_buf <= addr;
    end
  end

  // array read: new request on accept, replay of the buffered one after refill
  assign rd_en     = ready_out || refill_done;
  assign rd_index  = ready_out ? addr.index : addr_buf.index;
  assign rd_offset = ready_out ? addr.word : addr_buf.word;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid <= 1'b0;
    end else if (rd_en) begin
      rd_valid <= line_valid[rd_index];
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_tag        <= line_tag[rd_index];
      rd_word.instr <= line_data[{rd_index, rd_offset}];
    end
  end

  // array writes from the refill controller
  always_ff @(posedge clk) begin
    if (rst) begin
      line_valid <= '0;
    end else if (fill_line_valid) begin
      line_valid[fill_word_index[FILL_W-1:WORD_W]] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_we) begin
      line_data[fill_word_index] <= fill_data;
    end
    if (fill_line_valid) begin
      line_tag[fill_word_index[FILL_W-1:WORD_W]] <= addr_buf.tag;  // tag of the stalled request
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      refill_busy <= 1'b0;
      miss_count  <= '0;
    end else begin
      if (start) begin
        refill_busy <= 1'b1;
      end else if (refill_done) begin
        refill_busy <= 1'b0;
      end
      if (start && (miss_count != 16'hffff)) begin
        miss_count <= miss_count + 16'd1;  // saturates
      end
    end
  end

  icache_refill u_refill (
    .clk             (clk),
    .rst             (rst),
    .start           (start),
    .line_addr       (addr_buf),
    .mem_stb         (mem_stb),
    .mem_req         (mem_req),
    .mem_ack         (mem_ack),
    .mem_resp        (mem_resp),
    .fill_we         (fill_we),
    .fill_word_index (fill_word_index),
    .fill_data       (fill_data),
    .fill_line_valid (fill_line_valid),
    .refill_done     (refill_done)
  );

endmodule

`default_nettype wire

// File: rtl/main_memory.sv
// read-only word memory from prog.hex; acks MEM_LATENCY cycles after a new strobe
// addresses wrap modulo MEM_WORDS, which must be a power of two
`default_nettype none

module main_memory #(
  parameter int MEM_LATENCY = 2,
  parameter int MEM_WORDS   = 32
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  mem_stb,
  input  icache_pkg::mem_req_t  mem_req,
  output logic                  mem_ack,
  output icache_pkg::mem_resp_t mem_resp
);
  localparam int ADDR_W = $clog2(MEM_WORDS);
  localparam int CNT_W  = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;

  logic [31:0]       mem [MEM_WORDS];
  logic [CNT_W-1:0]  wait_cnt;
  logic [ADDR_W-1:0] word_sel;
  logic              answer;

  initial begin
    $readmemh("prog.hex", mem);
  end

  assign word_sel = mem_req.word_addr[ADDR_W-1:0];  // upper bits alias
  assign answer   = mem_stb && !mem_ack && (wait_cnt == CNT_W'(MEM_LATENCY - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_ack  <= 1'b0;
      wait_cnt <= '0;
    end else if (mem_ack) begin
      mem_ack <= 1'b0;  // single-cycle ack, next strobe counts afresh
    end else if (answer) begin
      mem_ack  <= 1'b1;
      wait_cnt <= '0;
    end else if (mem_stb) begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (answer) begin
      mem_resp.rdata <= mem[word_sel];
    end
  end

endmodule

`default_nettype wire

// File: rtl/fetch_top.sv
// instruction cache plus its backing memory
// MEM_LATENCY and MEM_WORDS only affect main_memory
`default_nettype none

module fetch_top #(
  parameter int MEM_LATENCY = 2,
  parameter int MEM_WORDS   = 32
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    valid,
  input  icache_pkg::fetch_addr_t addr,
  output logic                    ready_out,
  input  logic                    ready_in,
  output logic                    valid_out,
  output icache_pkg::fetch_resp_t data,
  output logic [15:0]             miss_count
);
  import icache_pkg::*;

  logic      mem_stb;
  mem_req_t  mem_req;
  logic      mem_ack;
  mem_resp_t mem_resp;

  icache u_icache (
    .clk        (clk),
    .rst        (rst),
    .valid      (valid),
    .addr       (addr),
    .ready_out  (ready_out),
    .ready_in   (ready_in),
    .valid_out  (valid_out),
    .data       (data),
    .mem_stb    (mem_stb),
    .mem_req    (mem_req),
    .mem_ack    (mem_ack),
    .mem_resp   (mem_resp),
    .miss_count (miss_count)
  );

  main_memory #(
    .MEM_LATENCY (MEM_LATENCY),
    .MEM_WORDS   (MEM_WORDS)
  ) u_mem (
    .clk      (clk),
    .rst      (rst),
    .mem_stb  (mem_stb),
    .mem_req  (mem_req),
    .mem_ack  (mem_ack),
    .mem_resp (mem_resp)
  );

endmodule

`default_nettype wire

// File: tb/icache_assertions.sv
// bound into icache; watches the memory strobe, the output hold and refill writes
// fail_count is read by the testbench at the end of the run
`default_nettype none

module icache_assertions (
  input logic                    clk,
  input logic                    rst,
  input logic                    mem_stb,
  input icache_pkg::mem_req_t    mem_req,
  input logic                    mem_ack,
  input logic                    ready_in,
  input logic                    valid_out,
  input icache_pkg::fetch_resp_t data,
  input logic                    fill_we,
  input logic                    refill_busy
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_count = 0;

  stb_held: assert property (@(posedge clk) disable iff (rst)
    mem_stb && !mem_ack |=> mem_stb && $stable(mem_req))  // held until the ack cycle
    else begin
      $error("mem_stb dropped or mem_req changed before mem_ack");
      fail_count++;
    end

  data_held: assert property (@(posedge clk) disable iff (rst)
    valid_out && !ready_in |=> valid_out && $stable(data))
    else begin
      $error("output word changed or vanished while the consumer stalled");
      fail_count++;
    end

  fill_in_refill: assert property (@(posedge clk) disable iff (rst)
    fill_we |-> refill_busy)
    else begin
      $error("array write outside a refill");
      fail_count++;
    end

endmodule

bind icache icache_assertions u_icache_assertions (.*);

`default_nettype wire

// File: tb/icache_tb.sv
// drives fetch_top from an address table with random consumer stalls
// expects prog.hex in the working directory; MEM_WORDS matches its 32 words
`default_nettype none

module icache_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import icache_pkg::*;

  localparam int MEM_LATENCY     = 2;
  localparam int MEM_WORDS       = 32;
  localparam int SEL_W           = $clog2(MEM_WORDS);
  localparam int NUM_TESTS       = 24;
  localparam int RESET_AT        = 18;  // second reset before this entry
  localparam int WATCHDOG_CYCLES = NUM_TESTS * (8 * (MEM_LATENCY + 1) + 20);

  logic        clk;
  logic        rst;
  logic        valid;
  fetch_addr_t addr;
  logic        ready_out;
  logic        ready_in;
  logic        valid_out;
  fetch_resp_t data;
  logic [15:0] miss_count;

  logic [31:0]      hex_words [MEM_WORDS];
  logic             model_valid [NUM_LINES];  // tag model of the cache
  logic [TAG_W-1:0] model_tag [NUM_LINES];
  int               exp_misses;
  int               deliv_idx;
  int               data_errors;
  int               count_errors;
  int               order_errors;
  integer           seed;

  // tag = addr[23:14], index = addr[13:5], word = addr[4:2]
  string test_name [NUM_TESTS] = '{
    "cold_l0_w0", "l0_w1", "l0_w7", "l0_w3", "cold_l1_w0", "l1_w5",
    "cold_l2_w2", "cold_l3_w7", "alias_l0_t1", "alias_l0_t1_w6", "evict_back_l0", "alias_l1_t2",
    "evict_back_l1", "l3_w0", "high_tag_l2", "high_tag_l2_w2", "last_line", "last_line_w7",
    "reset_l0", "reset_l0_w2", "reset_l3", "reset_l0_w0", "alias_l3_t5", "evict_back_l3"};
  logic [23:0] test_addr [NUM_TESTS] = '{
    24'h000000, 24'h000004, 24'h00001c, 24'h00000c, 24'h000020, 24'h000034,
    24'h000048, 24'h00007c, 24'h004000, 24'h004018, 24'h000010, 24'h008024,
    24'h000028, 24'h000060, 24'hffc044, 24'hffc048, 24'h003fe0, 24'h003ffc,
    24'h000010, 24'h000008, 24'h000060, 24'h000000, 24'h014070, 24'h00007c};

  fetch_top #(.MEM_LATENCY (MEM_LATENCY), .MEM_WORDS (MEM_WORDS)) dut (
    .clk        (clk),
    .rst        (rst),
    .valid      (valid),
    .addr       (addr),
    .ready_out  (ready_out),
    .ready_in   (ready_in),
    .valid_out  (valid_out),
    .data       (data),
    .miss_count (miss_count)
  );

  task automatic clear_model();
    int n;
    for (n = 0; n < NUM_LINES; n++) begin
      model_valid[n] = 1'b0;
    end
    exp_misses = 0;
  endtask

  task automatic check_delivery();
    fetch_addr_t a;
    logic [31:0] exp_word;
    if (deliv_idx >= NUM_TESTS) begin
      order_errors++;
      $display("Unexpected extra word %h delivered after the last entry", data.instr);
    end else begin
      a        = test_addr[deliv_idx];
      exp_word = hex_words[SEL_W'({a.tag, a.index, a.word} % MEM_WORDS)];  // upper bits alias
      if (!model_valid[a.index] || model_tag[a.index] != a.tag) begin
        model_valid[a.index] = 1'b1;
        model_tag[a.index]   = a.tag;
        exp_misses++;
      end
      if (data.instr !== exp_word) begin
        data_errors++;
        $display("Error: %s data expected %h actual %h",
                 test_name[deliv_idx], exp_word, data.instr);
      end
      if (miss_count !== 16'(exp_misses)) begin
        count_errors++;
        $display("Error: %s miss_count expected %0d actual %0d",
                 test_name[deliv_idx], exp_misses, miss_count);
      end
      deliv_idx++;
    end
  endtask

  task automatic apply_reset(input string name);
    rst <= 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    clear_model();
    @(posedge clk);
    if (miss_count !== 16'd0) begin
      count_errors++;
      $display("Error: %s miss_count after reset expected 0 actual %0d", name, miss_count);
    end
    if (valid_out !== 1'b0) begin
      order_errors++;
      $display("Error: %s valid_out after reset expected 0 actual %b", name, valid_out);
    end
    if (ready_out !== ready_in) begin  // nothing buffered, follows the consumer
      order_errors++;
      $display("Error: %s ready_out after reset expected %b actual %b",
               name, ready_in, ready_out);
    end
  endtask

  task automatic finish_run();
    int assert_errors;
    assert_errors = dut.u_icache.u_icache_assertions.fail_count;
    $display("errors: data %0d, miss count %0d, delivery %0d, assertion %0d",
             data_errors, count_errors, order_errors, assert_errors);
    if (data_errors + count_errors + order_errors + assert_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin : drive
    int i;
    rst   = 1'b1;
    valid = 1'b0;
    addr  = '0;
    seed  = 115;
    $readmemh("prog.hex", hex_words);
    clear_model();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    for (i = 0; i < NUM_TESTS; i++) begin
      if (i == RESET_AT) begin
        valid <= 1'b0;
        wait (deliv_idx == i);  // pipeline drained
        apply_reset(test_name[i]);
      end
      valid <= 1'b1;
      addr  <= test_addr[i];
      @(posedge clk);
      while (!ready_out) @(posedge clk);
    end
    valid <= 1'b0;
    wait (deliv_idx == NUM_TESTS);
    repeat (4) @(posedge clk);  // room for a duplicate to show up
    finish_run();
  end

  initial begin : consume
    ready_in = 1'b0;
    forever begin
      @(posedge clk);
      ready_in <= (($random(seed) & 3) != 0);  // stalls about one cycle in four
      if (!rst && valid_out && ready_in) begin
        check_delivery();
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: %0d of %0d entries delivered after %0d cycles",
             deliv_idx, NUM_TESTS, WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
rtl/icache_pkg.sv
rtl/icache_refill.sv
rtl/icache.sv
rtl/main_memory.sv
rtl/fetch_top.sv
tb/icache_assertions.sv
tb/icache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
RUN_FLAGS ?= +verilator+error+limit+100
PASS_MSG  ?= Simulation PASSED

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(RUN_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: prog.hex
// main memory image: one 32-bit word per line, word address 0 to 31
c0de00ff
c0de01fe
c0de02fd
c0de03fc
c0de04fb
c0de05fa
c0de06f9
c0de07f8
c0de08f7
c0de09f6
c0de0af5
c0de0bf4
c0de0cf3
c0de0df2
c0de0ef1
c0de0ff0
c0de10ef
c0de11ee
c0de12ed
c0de13ec
c0de14eb
c0de15ea
c0de16e9
c0de17e8
c0de18e7
c0de19e6
c0de1ae5
c0de1be4
c0de1ce3
c0de1de2
c0de1ee1
c0de1fe0
